// ==== source/dcache_cfg.svh ====
// fixed 2-way dcache geometry; changing a width here means re-deriving the address split by hand
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address split for 32-bit byte addresses
// tag | index | block offset | byte offset
// 26  |   3   |      1       |      2

// tag bits kept per block
`define DCACHE_TAG_W 26

// set index bits
`define DCACHE_IDX_W 3

// sets per way, must equal 2**DCACHE_IDX_W
`define DCACHE_SETS 8

// where the flush sequence stores the hit count
`define DCACHE_HIT_CNT_ADDR 32'h3100

// hit counter value out of reset
`define DCACHE_CNT_RST 32'h0000_0000

// two words per block, one block offset bit
// byte writes are not supported, stores are full words

`endif

// ==== source/dcache_pkg.sv ====
// shared dcache types; widths follow dcache_cfg.svh, state encoding is not meant to be stable
`include "dcache_cfg.svh"

package dcache_pkg;

  // datapath word and byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // block tag and set index
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [`DCACHE_IDX_W-1:0] idx_t;

  // hits counted while idle, retries excluded
  typedef logic [31:0] hit_cnt_t;

  // controller FSM
  // wb* write back a dirty victim, ld* fill the block
  // flush_* walk every set and way after halt
  typedef enum logic [3:0] {
    idle,
    wb0,          // victim word 0 out
    wb1,          // victim word 1 out, dirty cleared
    ld0,          // fill word 0
    ld1,          // fill word 1, tag installed
    flush_scan,   // one block per cycle when clean
    flush_wb0,
    flush_wb1,
    cnt_wr,       // hit count to memory
    done          // flushed held until reset
  } ctrl_state_t;

endpackage

// ==== source/dcache_way.sv ====
// one dcache way: 8 sets of tag/valid/dirty and two words, async read, one write port
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_way (
  input  logic              CLK,
  input  logic              rst,
  input  dcache_pkg::idx_t  idx,
  input  logic              offset,
  input  dcache_pkg::tag_t  req_tag,
  input  logic              wen,
  input  logic              fill,
  input  logic              clean,
  input  dcache_pkg::word_t wdata,
  input  dcache_pkg::tag_t  new_tag,
  output logic              hit,
  output logic              valid,
  output logic              dirty,
  output dcache_pkg::tag_t  tag,
  output dcache_pkg::word_t rdata
);
  import dcache_pkg::*;

  tag_t                    tag_mem  [`DCACHE_SETS];
  word_t                   data_mem [`DCACHE_SETS][2];
  logic [`DCACHE_SETS-1:0] valid_q;
  logic [`DCACHE_SETS-1:0] dirty_q;

  // lookup for the selected set
  assign valid = valid_q[idx];
  assign dirty = dirty_q[idx];
  assign tag   = tag_mem[idx];
  assign rdata = data_mem[idx][offset];
  assign hit   = valid_q[idx] && (tag_mem[idx] == req_tag);

  // status bits
  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (fill) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;      // fresh block from memory
      end else if (wen) begin
        dirty_q[idx] <= 1'b1;      // store hit
      end else if (clean) begin
        dirty_q[idx] <= 1'b0;      // written back
      end
    end
  end

  // tag array
  always_ff @(posedge CLK) begin
    if (fill) begin
      tag_mem[idx] <= new_tag;
    end
  end

  // data array, one word per write
  always_ff @(posedge CLK) begin
    if (wen) begin
      data_mem[idx][offset] <= wdata;
    end
  end

  // controller never fills and cleans the same way at once
  a_fill_clean_excl : assert property (
    @(posedge CLK) disable iff (rst) !(fill && clean)
  ) else $error("dcache_way: fill and clean together");

endmodule

// ==== source/dcache_ctrl.sv ====
// dcache controller: one request at a time, LRU per set, write-back then fill, flush on halt
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                CLK,
  input  logic                rst,
  input  logic                dmem_ren,
  input  logic                dmem_wen,
  input  logic                halt,
  input  dcache_pkg::addr_t   dmem_addr,
  input  dcache_pkg::word_t   dmem_store,
  output dcache_pkg::word_t   dmem_load,
  output logic                dhit,
  output logic                flushed,
  output logic                dread,
  output logic                dwrite,
  output dcache_pkg::addr_t   daddr,
  output dcache_pkg::word_t   dstore,
  input  logic                dwait,
  input  dcache_pkg::word_t   dload,
  input  logic                hit0,
  input  logic                hit1,
  input  logic                valid0,
  input  logic                valid1,
  input  logic                dirty0,
  input  logic                dirty1,
  input  dcache_pkg::tag_t    tag0,
  input  dcache_pkg::tag_t    tag1,
  input  dcache_pkg::word_t   rdata0,
  input  dcache_pkg::word_t   rdata1,
  output dcache_pkg::idx_t    idx,
  output logic                offset,
  output logic                wen0,
  output logic                wen1,
  output logic                fill0,
  output logic                fill1,
  output logic                clean0,
  output logic                clean1,
  output dcache_pkg::word_t   wdata,
  output dcache_pkg::tag_t    new_tag
);
  import dcache_pkg::*;

  ctrl_state_t             state;
  ctrl_state_t             state_nxt;
  logic [`DCACHE_SETS-1:0] lru;            // 1 means way1 is least recent
  logic                    vict_way;
  logic                    vict_nxt;
  logic                    vict_dirty;
  logic [`DCACHE_IDX_W:0]  flush_ptr;      // {set, way}
  idx_t                    flush_idx;
  logic                    flush_last;
  logic                    flush_st;
  hit_cnt_t                hit_cnt;
  logic                    retry;          // next hit is the replay of a miss
  tag_t                    req_tag;
  idx_t                    req_idx;
  logic                    req_off;
  logic                    req;
  logic                    sel_way;
  tag_t                    sel_tag;
  word_t                   sel_data;
  logic                    sel_dirty;

  assign req_tag = dmem_addr[31 -: `DCACHE_TAG_W];
  assign req_idx = dmem_addr[3 +: `DCACHE_IDX_W];
  assign req_off = dmem_addr[2];
  assign req     = dmem_ren || dmem_wen;
  assign new_tag = req_tag;

  assign flush_idx  = flush_ptr[`DCACHE_IDX_W:1];
  assign flush_last = &flush_ptr;
  assign flush_st   = state inside {flush_scan, flush_wb0, flush_wb1};

  // invalid way first, else LRU
  assign vict_nxt   = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru[req_idx]);
  assign vict_dirty = vict_nxt ? dirty1 : dirty0;

  // way being written back or filled
  assign sel_way   = flush_st ? flush_ptr[0] : vict_way;
  assign sel_tag   = sel_way ? tag1 : tag0;
  assign sel_data  = sel_way ? rdata1 : rdata0;
  assign sel_dirty = sel_way ? dirty1 : dirty0;

  // hit path, same cycle as the request
  assign dhit      = (state == idle) && !halt && req && (hit0 || hit1);
  assign dmem_load = hit1 ? rdata1 : rdata0;
  assign flushed   = (state == done);

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (halt) begin
          state_nxt = flush_scan;
        end else if (req && !(hit0 || hit1)) begin
          state_nxt = vict_dirty ? wb0 : ld0;
        end
      end
      wb0:        if (!dwait) state_nxt = wb1;
      wb1:        if (!dwait) state_nxt = ld0;
      ld0:        if (!dwait) state_nxt = ld1;
      ld1:        if (!dwait) state_nxt = idle;    // request retries and hits
      flush_scan: begin
        if (sel_dirty) begin
          state_nxt = flush_wb0;
        end else if (flush_last) begin
          state_nxt = cnt_wr;
        end
      end
      flush_wb0:  if (!dwait) state_nxt = flush_wb1;
      flush_wb1:  if (!dwait) state_nxt = flush_last ? cnt_wr : flush_scan;
      cnt_wr:     if (!dwait) state_nxt = done;
      done:       state_nxt = done;
      default:    state_nxt = idle;
    endcase
  end

  // memory side and way write strobes
  always_comb begin
    dread  = 1'b0;
    dwrite = 1'b0;
    daddr  = '0;
    dstore = sel_data;
    idx    = flush_st ? flush_idx : req_idx;
    offset = req_off;
    wdata  = dmem_store;
    wen0   = 1'b0;
    wen1   = 1'b0;
    fill0  = 1'b0;
    fill1  = 1'b0;
    clean0 = 1'b0;
    clean1 = 1'b0;
    case (state)
      idle: begin
        if (dhit && dmem_wen) begin
          wen0 = hit0;
          wen1 = hit1;
        end
      end
      wb0, flush_wb0: begin
        dwrite = 1'b1;
        offset = 1'b0;
        daddr  = {sel_tag, idx, 1'b0, 2'b00};
      end
      wb1, flush_wb1: begin
        dwrite = 1'b1;
        offset = 1'b1;
        daddr  = {sel_tag, idx, 1'b1, 2'b00};
        clean0 = !dwait && !sel_way;
        clean1 = !dwait && sel_way;
      end
      ld0, ld1: begin
        dread  = 1'b1;
        offset = (state == ld1);
        daddr  = {req_tag, req_idx, offset, 2'b00};
        wdata  = dload;
        wen0   = !dwait && !sel_way;
        wen1   = !dwait && sel_way;
        fill0  = (state == ld1) && !dwait && !sel_way;    // tag with last word
        fill1  = (state == ld1) && !dwait && sel_way;
      end
      cnt_wr: begin
        dwrite = 1'b1;
        daddr  = `DCACHE_HIT_CNT_ADDR;
        dstore = hit_cnt;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= idle;
      lru       <= '0;
      vict_way  <= 1'b0;
      flush_ptr <= '0;
      hit_cnt   <= `DCACHE_CNT_RST;
      retry     <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == idle) begin
        vict_way <= vict_nxt;    // frozen for the rest of the miss
      end
      if (dhit) begin
        lru[req_idx] <= hit0;    // other way becomes LRU
        retry        <= 1'b0;
        if (!retry) begin
          hit_cnt <= hit_cnt + 1'b1;
        end
      end
      if ((state == ld1) && !dwait) begin
        retry <= 1'b1;
      end
      // next block once this one is clean or written back
      if (((state == flush_scan) && !sel_dirty) || ((state == flush_wb1) && !dwait)) begin
        if (!flush_last) begin
          flush_ptr <= flush_ptr + 1'b1;
        end
      end
    end
  end

  // a block lives in at most one way of its set
  a_single_hit : assert property (
    @(posedge CLK) disable iff (rst) !(hit0 && hit1)
  ) else $error("dcache_ctrl: both ways hit");

  // write data comes from the way array and must not drift
  a_dstore_hold : assert property (
    @(posedge CLK) disable iff (rst) (dwait && dwrite) |=> $stable(dstore)
  ) else $error("dcache_ctrl: dstore moved while dwait high");

  // memory sees a steady address for the whole transfer
  a_daddr_hold : assert property (
    @(posedge CLK) disable iff (rst) (dwait && (dread || dwrite)) |=> $stable(daddr)
  ) else $error("dcache_ctrl: daddr moved while dwait high");

endmodule

// ==== source/dcache.sv ====
// dcache top: two ways plus controller, word-aligned requests only, one outstanding at a time
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache (
  input  logic              CLK,
  input  logic              rst,
  input  logic              halt,
  input  logic              dmem_ren,
  input  logic              dmem_wen,
  input  dcache_pkg::addr_t dmem_addr,
  input  dcache_pkg::word_t dmem_store,
  output logic              dhit,
  output logic              flushed,
  output dcache_pkg::word_t dmem_load,
  output logic              dread,
  output logic              dwrite,
  output dcache_pkg::addr_t daddr,
  output dcache_pkg::word_t dstore,
  input  logic              dwait,
  input  dcache_pkg::word_t dload
);
  import dcache_pkg::*;

  tag_t  req_tag;              // compared in both ways
  idx_t  idx;
  logic  offset;
  word_t wdata;
  tag_t  new_tag;
  logic  hit0, hit1;
  logic  valid0, valid1;
  logic  dirty0, dirty1;
  tag_t  tag0, tag1;
  word_t rdata0, rdata1;
  logic  wen0, wen1;
  logic  fill0, fill1;
  logic  clean0, clean1;

  // upper bits of the byte address, index and offset are taken in the controller
  assign req_tag = dmem_addr[31 -: `DCACHE_TAG_W];

  dcache_way way0_i (
    .CLK(CLK), .rst(rst),
    .idx(idx), .offset(offset), .req_tag(req_tag),
    .wen(wen0), .fill(fill0), .clean(clean0),
    .wdata(wdata), .new_tag(new_tag),
    .hit(hit0), .valid(valid0), .dirty(dirty0),
    .tag(tag0), .rdata(rdata0)
  );

  dcache_way way1_i (
    .CLK(CLK), .rst(rst),
    .idx(idx), .offset(offset), .req_tag(req_tag),
    .wen(wen1), .fill(fill1), .clean(clean1),
    .wdata(wdata), .new_tag(new_tag),
    .hit(hit1), .valid(valid1), .dirty(dirty1),
    .tag(tag1), .rdata(rdata1)
  );

  dcache_ctrl ctrl_i (
    .CLK(CLK), .rst(rst),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .halt(halt),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store),
    .dmem_load(dmem_load), .dhit(dhit), .flushed(flushed),
    .dread(dread), .dwrite(dwrite), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload),
    .hit0(hit0), .hit1(hit1),
    .valid0(valid0), .valid1(valid1),
    .dirty0(dirty0), .dirty1(dirty1),
    .tag0(tag0), .tag1(tag1),
    .rdata0(rdata0), .rdata1(rdata1),
    .idx(idx), .offset(offset),
    .wen0(wen0), .wen1(wen1),
    .fill0(fill0), .fill1(fill1),
    .clean0(clean0), .clean1(clean1),
    .wdata(wdata), .new_tag(new_tag)
  );

endmodule

// ==== tb/dcache_tb.sv ====
// dcache testbench; memory model covers byte addresses below 0x100 only, the hit count word is kept apart
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int REQ_TIMEOUT   = 200;    // cycles per request, misses included
  localparam int FLUSH_TIMEOUT = 2000;

  logic  CLK;
  logic  rst;
  logic  halt;
  logic  dmem_ren;
  logic  dmem_wen;
  addr_t dmem_addr;
  word_t dmem_store;
  logic  dhit;
  logic  flushed;
  word_t dmem_load;
  logic  dread;
  logic  dwrite;
  addr_t daddr;
  word_t dstore;
  logic  dwait;
  word_t dload;

  word_t    mem    [64];    // what the cache has written so far
  word_t    golden [64];    // what the datapath has stored so far
  hit_cnt_t cnt_word;
  logic     cnt_seen;
  integer   seed;
  int       checks;
  int       value_errs;
  int       other_errs;
  logic     timed_out;
  logic     saw_halt;

  // transfer in flight in the memory model
  logic  busy;
  int    wait_left;
  logic  held_rd;
  addr_t held_addr;
  word_t held_store;

  dcache dcache_i (
    .CLK(CLK), .rst(rst),
    .halt(halt), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store),
    .dhit(dhit), .flushed(flushed), .dmem_load(dmem_load),
    .dread(dread), .dwrite(dwrite), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload)
  );

  always #2 CLK = ~CLK;

  function automatic int word_of(input addr_t a);
    return int'(a[7:2]);
  endfunction

  function automatic logic in_model(input addr_t a);
    return (a[31:8] == '0);
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input hit_cnt_t got, input hit_cnt_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] hit_cnt got %h expected %h", got, exp);
    end
  endtask

  // runs on the negedge where dwait drops, the DUT takes it at the next posedge
  task automatic finish_transfer();
    if (held_rd) begin
      if (in_model(held_addr)) begin
        dload = mem[word_of(held_addr)];
      end else begin
        other_errs++;
        $display("cache read address %h lies outside the memory model", held_addr);
        dload = '0;
      end
    end else if (held_addr == `DCACHE_HIT_CNT_ADDR) begin
      cnt_word = held_store;
      cnt_seen = 1'b1;
    end else if (in_model(held_addr)) begin
      check_word("dstore", held_store, golden[word_of(held_addr)]);    // write-back data
      mem[word_of(held_addr)] = held_store;
    end else begin
      other_errs++;
      $display("cache wrote address %h outside the memory model", held_addr);
    end
  endtask

  // memory model, 1 to 3 wait cycles per word
  always @(negedge CLK) begin
    if (rst) begin
      dwait     = 1'b1;
      dload     = '0;
      busy      = 1'b0;
      wait_left = 0;
    end else begin
      if (!dwait) begin    // last word went through at the posedge
        dwait = 1'b1;
        busy  = 1'b0;
      end
      if (busy) begin
        check_word("daddr", daddr, held_addr);
        if ((dread !== held_rd) || (dwrite !== !held_rd)) begin
          other_errs++;
          $display("dread or dwrite changed while dwait was high at %0t", $time);
        end
        if (!held_rd) begin
          check_word("dstore", dstore, held_store);
        end
        if (wait_left == 0) begin
          dwait = 1'b0;
          finish_transfer();
        end else begin
          wait_left--;
        end
      end else if (dread || dwrite) begin
        busy       = 1'b1;
        held_rd    = dread;
        held_addr  = daddr;
        held_store = dstore;
        wait_left  = $unsigned($random(seed)) % 3;
      end
    end
  end

  // one request held until dhit, sampled 1 ns after the falling edge
  task automatic do_request(input logic wr, input addr_t addr, input word_t data,
                            output word_t load);
    int cycles;
    @(negedge CLK);
    dmem_ren   = !wr;
    dmem_wen   = wr;
    dmem_addr  = addr;
    dmem_store = data;
    cycles     = 0;
    #1;
    while (!dhit && (cycles < REQ_TIMEOUT)) begin
      @(negedge CLK);
      #1;
      cycles++;
    end
    if (!dhit) begin
      other_errs++;
      timed_out = 1'b1;
      $display("no dhit within %0d cycles for address %h", REQ_TIMEOUT, addr);
    end
    load = dmem_load;
  endtask

  task automatic run_flush(input hit_cnt_t exp_cnt);
    int cycles;
    int i;
    @(negedge CLK);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    halt     = 1'b1;
    cycles   = 0;
    while (!flushed && (cycles < FLUSH_TIMEOUT)) begin
      @(negedge CLK);
      cycles++;
    end
    if (!flushed) begin
      other_errs++;
      timed_out = 1'b1;
      $display("flushed did not rise within %0d cycles of halt", FLUSH_TIMEOUT);
    end else begin
      for (i = 0; i < 64; i++) begin
        check_word($sformatf("mem[%0d]", i), mem[i], golden[i]);
      end
      if (!cnt_seen) begin
        other_errs++;
        $display("the flush never wrote the hit count to its address");
      end else begin
        check_count(cnt_word, exp_cnt);
      end
    end
  endtask

  task automatic play_patterns();
    integer             fd;
    integer             n;
    logic [7:0]         op;
    addr_t              a;
    word_t              d;
    word_t              load;
    hit_cnt_t           exp_cnt;
    logic [8*128-1:0]   skip;
    fd = $fopen("tb/dcache_patterns.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open tb/dcache_patterns.txt");
      return;
    end
    while (!timed_out && ($fscanf(fd, " %c", op) == 1)) begin
      case (op)
        "#": n = $fgets(skip, fd);
        "R": begin
          n = $fscanf(fd, "%h %h", a, d);
          do_request(1'b0, a, '0, load);
          if (!timed_out) begin
            check_word("dmem_load", load, d);
            check_word("dmem_load (golden)", load, golden[word_of(a)]);
          end
        end
        "W": begin
          n = $fscanf(fd, "%h %h", a, d);
          do_request(1'b1, a, d, load);
          golden[word_of(a)] = d;
        end
        "H": begin
          n = $fscanf(fd, "%h", exp_cnt);
          saw_halt = 1'b1;
          run_flush(exp_cnt);
        end
        default: begin
          other_errs++;
          $display("unknown line code '%c' in the pattern file", op);
        end
      endcase
    end
    $fclose(fd);
    if (!saw_halt && !timed_out) begin
      other_errs++;
      $display("pattern file ended without an H line");
    end
  endtask

  task automatic end_run();
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    CLK        = 1'b0;
    rst        = 1'b1;
    halt       = 1'b0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    dmem_addr  = '0;
    dmem_store = '0;
    dwait      = 1'b1;
    dload      = '0;
    seed       = 95;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    timed_out  = 1'b0;
    saw_halt   = 1'b0;
    cnt_word   = '0;
    cnt_seen   = 1'b0;
    busy       = 1'b0;
    wait_left  = 0;
    for (int i = 0; i < 64; i++) begin
      mem[i]    = '0;
      golden[i] = '0;
    end
    repeat (8) @(negedge CLK);
    rst = 1'b0;
    play_patterns();
    end_run();
  end

endmodule

// ==== tb/dcache_patterns.txt ====
# R address expected_load | W address store_data | H expected_hit_count, all hex
# addresses stay below 0x100 with bit 5 clear; memory starts at zero
# set 0: empty miss, write hits, LRU eviction of dirty blocks
R 00000000 00000000
W 00000000 11111111
W 00000000 22222222
W 00000000 33333333
R 00000000 33333333
R 00000004 00000000
W 00000040 aaaa0001
W 00000044 aaaa0002
R 00000080 00000000
R 00000000 33333333
R 00000044 aaaa0002
R 00000040 aaaa0001
# set 1: four tags through one set, every victim dirty
W 00000008 b0000001
W 0000004c b0000002
W 0000008c b0000003
W 000000c8 b0000004
R 00000008 b0000001
R 0000004c b0000002
R 0000000c 00000000
# set 2: both ways filled, hits on each
W 00000010 c0000001
W 00000014 c0000002
R 00000050 00000000
R 00000010 c0000001
R 00000054 00000000
# set 3: mixed clean and dirty victims
W 0000001c d0000001
W 0000005c d0000002
R 00000018 00000000
R 0000001c d0000001
W 000000dc d0000003
R 0000005c d0000002
R 000000dc d0000003
R 0000001c d0000001
# back to set 0, hits in way 1
W 00000004 e0000001
R 00000004 e0000001
# halt and flush, 16 first-try hits
H 00000010

// ==== flist.f ====
+incdir+source
source/dcache_pkg.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache.sv
tb/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_pkg.sv
      - source/dcache_way.sv
      - source/dcache_ctrl.sv
      - source/dcache.sv
      - target: test
        files:
          - tb/dcache_tb.sv
